/* files.f */
+incdir+src
src/mipsIsaPkg.sv
src/mipsPipePkg.sv
src/branchHistoryTable.sv
src/fetchStage.sv
src/registerFile.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/mipsCore.sv
test/mipsCore_sva.sv
test/tb_mipsCore.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_mipsCore
FILELIST  := files.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert --top-module $(TOP) -Mdir $(BUILD_DIR)
SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard src/*.sv src/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

/* test/tb_mipsCore.sv */
`include "mips_defines.svh"

module tb_mipsCore;
    import mipsIsaPkg::*;
    import mipsPipePkg::*;

    localparam int ProgLen = 48;
    localparam int MemWords = 64;
    localparam int RunTimeout = 1000;

    logic        CLK;
    logic        rstN;
    wordT        instrAddr;
    wordT        instrRead;
    dmemReqT     dmemReq;
    wordT        dataRead;

    wordT        imem [MemWords];
    wordT        dmem [MemWords];
    dmemReqT     expStores [$];
    wordT        expLoads [$];
    logic [31:0] lfsr;
    int          seenStores;
    int          modelStores;
    int          seenLoads;
    int          modelLoads;

    mipsCore u_mipsCore (
        .CLK      (CLK),
        .rstN     (rstN),
        .instrAddr(instrAddr),
        .instrRead(instrRead),
        .dmemReq  (dmemReq),
        .dataRead (dataRead)
    );

    always #5 CLK = ~CLK;

    // Both memories answer in the same cycle
    assign instrRead = imem[instrAddr[7:2]];
    assign dataRead = dmem[dmemReq.addr[7:2]];

    // Data memory refills while reset is held
    always @(posedge CLK) begin
        if (!rstN) begin
            for (int i = 0; i < MemWords; i++) begin
                dmem[i] <= fillWord(i);
            end
        end else if (dmemReq.write) begin
            dmem[dmemReq.addr[7:2]] <= dmemReq.wdata;
        end
    end

    // ------------------------------------------------------------------------
    // Random source and instruction encoding
    // ------------------------------------------------------------------------
    function automatic wordT randBits(int width);
        wordT value;
        logic feedback;
        value = '0;
        for (int i = 0; i < width; i++) begin
            // Taps 32, 22, 2, 1
            feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic wordT fillWord(int index);
        return (wordT'(index * 4) * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    // Working registers 1 to 7
    function automatic regIdxT pickReg();
        wordT r;
        r = randBits(3);
        return regIdxT'(r % 7 + 1);
    endfunction

    function automatic functT pickFunct();
        wordT r;
        r = randBits(3);
        case (r % 5)
            0: return FN_ADDU;
            1: return FN_SUBU;
            2: return FN_AND;
            3: return FN_OR;
            default: return FN_SLT;
        endcase
    endfunction

    // Aligned byte offset inside the data window
    function automatic logic [15:0] wordOffset();
        wordT r;
        r = randBits(6);
        return {8'h00, r[5:0], 2'b00};
    endfunction

    function automatic wordT rType(functT funct, regIdxT rs, regIdxT rt, regIdxT rd);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic wordT iType(opcodeT op, regIdxT rs, regIdxT rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    task automatic stopRun(string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkWord(string name, wordT got, wordT expected);
        if (got !== expected) begin
            stopRun($sformatf("** Error at time %0t: %s = 0x%08h, expected 0x%08h",
                              $time, name, got, expected));
        end
    endtask

    task automatic checkStore(dmemReqT got, dmemReqT expected);
        checkWord("dmemReq.addr", got.addr, expected.addr);
        checkWord("dmemReq.wdata", got.wdata, expected.wdata);
    endtask

    task automatic observeStores();
        dmemReqT expected;
        if (dmemReq.write) begin
            if (expStores.size() == 0) begin
                stopRun("a store was issued beyond the model's store list");
            end else begin
                expected = expStores.pop_front();
                checkStore(dmemReq, expected);
                seenStores++;
            end
        end
    endtask

    // Read strobe and load address against the model's load order
    task automatic observeLoads();
        wordT expected;
        if (dmemReq.read) begin
            if (expLoads.size() == 0) begin
                stopRun("a load was issued beyond the model's load list");
            end else begin
                expected = expLoads.pop_front();
                checkWord("dmemReq.addr", dmemReq.addr, expected);
                seenLoads++;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Program generator and ISA model
    // ------------------------------------------------------------------------
    task automatic buildProgram();
        wordT        kind;
        wordT        r;
        regIdxT      rs;
        regIdxT      rt;
        regIdxT      rd;
        int          offset;
        for (int i = 0; i < MemWords; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < ProgLen; i++) begin
            rs = pickReg();
            rt = pickReg();
            rd = pickReg();
            kind = randBits(3);
            case (kind)
                0, 1: imem[i] = rType(pickFunct(), rs, rt, rd);
                2: begin
                    r = randBits(16);
                    imem[i] = iType(OP_ADDIU, rs, rt, r[15:0]);
                end
                3: imem[i] = iType(OP_LW, '0, rt, wordOffset());
                4, 5: imem[i] = iType(OP_SW, '0, rt, wordOffset());
                default: begin
                    // Forward by 1 to 3, never past the halt word
                    r = randBits(2);
                    offset = 1 + int'(r % 3);
                    if (i + 1 + offset > ProgLen) begin
                        offset = ProgLen - 1 - i;
                    end
                    imem[i] = iType((kind == 6) ? OP_BEQ : OP_BNE, rs, rt, 16'(offset));
                end
            endcase
        end
        // Halt loop on itself
        imem[ProgLen] = iType(OP_BEQ, '0, '0, 16'hffff);
    endtask

    task automatic runModel();
        wordT    regs [32];
        wordT    mem [MemWords];
        wordT    instr;
        wordT    a;
        wordT    b;
        wordT    addr;
        wordT    result;
        dmemReqT store;
        int      pc;
        int      steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < MemWords; i++) begin
            mem[i] = fillWord(i);
        end
        expStores.delete();
        expLoads.delete();
        pc = 0;
        steps = 0;
        while (pc < ProgLen) begin
            instr = imem[pc];
            a = regs[instr[25:21]];
            b = regs[instr[20:16]];
            addr = a + {{16{instr[15]}}, instr[15:0]};
            pc++;
            case (instr[31:26])
                OP_SPECIAL: begin
                    case (instr[5:0])
                        FN_ADDU: result = a + b;
                        FN_SUBU: result = a - b;
                        FN_AND:  result = a & b;
                        FN_OR:   result = a | b;
                        FN_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: begin
                            result = '0;
                            stopRun("generator produced an unknown funct");
                        end
                    endcase
                    regs[instr[15:11]] = result;
                end
                OP_ADDIU: regs[instr[20:16]] = addr;
                OP_LW: begin
                    regs[instr[20:16]] = mem[addr[7:2]];
                    expLoads.push_back(addr);
                end
                OP_SW: begin
                    mem[addr[7:2]] = b;
                    store = {addr, b, 1'b0, 1'b1};
                    expStores.push_back(store);
                end
                OP_BEQ: pc += (a == b) ? int'(instr[15:0]) : 0;
                OP_BNE: pc += (a != b) ? int'(instr[15:0]) : 0;
                default: stopRun("generator produced an unknown opcode");
            endcase
            regs[0] = '0;
            steps++;
            if (steps > ProgLen) begin
                stopRun("model did not reach the halt instruction");
            end
        end
        modelStores = expStores.size();
        modelLoads = expLoads.size();
    endtask

    // ------------------------------------------------------------------------
    // Sequencing
    // ------------------------------------------------------------------------
    task automatic resetDut();
        @(posedge CLK);
        rstN <= 1'b0;
        for (int c = 0; c < 8; c++) begin
            @(negedge CLK);
            if (dmemReq.read || dmemReq.write) begin
                stopRun("a memory strobe was active during reset");
            end
            if (c == 0) begin
                buildProgram();
                runModel();
            end
            @(posedge CLK);
        end
        rstN <= 1'b1;
        @(negedge CLK);
        checkWord("instrAddr", instrAddr, `MIPS_RESET_PC);
    endtask

    task automatic runProgram(int index);
        wordT haltAddr;
        int   cycles;
        int   settled;
        haltAddr = `MIPS_RESET_PC + wordT'(ProgLen * 4);
        cycles = 0;
        settled = 0;
        seenStores = 0;
        seenLoads = 0;
        while (settled < 8) begin
            @(negedge CLK);
            observeStores();
            observeLoads();
            settled = (instrAddr == haltAddr) ? settled + 1 : 0;
            cycles++;
            if (cycles > RunTimeout) begin
                stopRun($sformatf("program %0d never settled on the halt address", index));
            end
        end
        // Quiet window on the halt loop
        repeat (20) begin
            @(negedge CLK);
            observeStores();
            observeLoads();
        end
        checkWord("store count", wordT'(seenStores), wordT'(modelStores));
        checkWord("load count", wordT'(seenLoads), wordT'(modelLoads));
    endtask

    initial begin
        CLK = 1'b0;
        rstN = 1'b0;
        lfsr = 32'h1966d4b3;
        for (int p = 0; p < 4; p++) begin
            resetDut();
            runProgram(p);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

/* test/mipsCore_sva.sv */
module mipsCore_sva (
    input logic                 CLK,
    input logic                 rstN,
    input mipsPipePkg::wordT    instrAddr,
    input mipsPipePkg::dmemReqT dmemReq
);

    // Pipeline valid bits are cleared while reset is held
    noStrobeInReset: assert property (
        @(posedge CLK) !rstN |-> !(dmemReq.read || dmemReq.write)
    ) else $error("memory strobe active while rstN is low");

    noReadWithWrite: assert property (
        @(posedge CLK) disable iff (!rstN) !(dmemReq.read && dmemReq.write)
    ) else $error("data memory read and write in the same cycle");

    instrAligned: assert property (
        @(posedge CLK) disable iff (!rstN) instrAddr[1:0] == 2'b00
    ) else $error("instrAddr is not word aligned");

    // Only checked while a strobe is up
    dataAligned: assert property (
        @(posedge CLK) disable iff (!rstN)
        (dmemReq.read || dmemReq.write) |-> dmemReq.addr[1:0] == 2'b00
    ) else $error("data address is not word aligned");

endmodule

bind mipsCore mipsCore_sva u_mipsCore_sva (
    .CLK      (CLK),
    .rstN     (rstN),
    .instrAddr(instrAddr),
    .dmemReq  (dmemReq)
);

/* src/mipsCore.sv */
`include "mips_defines.svh"

module mipsCore (
    input  logic                 CLK,
    input  logic                 rstN,
    output mipsPipePkg::wordT    instrAddr,
    input  mipsPipePkg::wordT    instrRead,
    output mipsPipePkg::dmemReqT dmemReq,
    input  mipsPipePkg::wordT    dataRead
);
    import mipsPipePkg::*;

    ifIdT      ifId;
    idExT      idEx;
    exMemT     exMem;
    memWbT     writeBack;
    redirectT  redirect;
    bhtUpdateT bhtUpdate;
    logic      stall;

    // Flush follows the redirect from the memory stage
    fetchStage u_fetchStage (
        .CLK      (CLK),
        .rstN     (rstN),
        .instrAddr(instrAddr),
        .instrRead(instrRead),
        .stall    (stall),
        .flush    (redirect.valid),
        .redirect (redirect),
        .bhtUpdate(bhtUpdate),
        .ifId     (ifId)
    );

    decodeStage u_decodeStage (
        .CLK      (CLK),
        .rstN     (rstN),
        .ifId     (ifId),
        .flush    (redirect.valid),
        .writeBack(writeBack),
        .exMem    (exMem),
        .idEx     (idEx),
        .stall    (stall)
    );

    executeStage u_executeStage (
        .CLK  (CLK),
        .rstN (rstN),
        .idEx (idEx),
        .flush(redirect.valid),
        .exMem(exMem)
    );

    memoryStage u_memoryStage (
        .exMem    (exMem),
        .dataRead (dataRead),
        .dmemReq  (dmemReq),
        .redirect (redirect),
        .bhtUpdate(bhtUpdate),
        .writeBack(writeBack),
        .CLK      (CLK),
        .rstN     (rstN)
    );

endmodule

/* src/memoryStage.sv */
`include "mips_defines.svh"

module memoryStage (
    input  mipsPipePkg::exMemT     exMem,
    input  mipsPipePkg::wordT      dataRead,
    output mipsPipePkg::dmemReqT   dmemReq,
    output mipsPipePkg::redirectT  redirect,
    output mipsPipePkg::bhtUpdateT bhtUpdate,
    output mipsPipePkg::memWbT     writeBack,
    input  logic                   CLK,
    input  logic                   rstN
);
    import mipsPipePkg::*;

    wordT fallThrough;
    logic isBranch;
    logic mispredict;

    // ------------------------------------------------------------------------
    // Data memory request
    // ------------------------------------------------------------------------
    assign dmemReq.addr = exMem.aluResult;
    assign dmemReq.wdata = exMem.storeData;
    assign dmemReq.read = exMem.valid && exMem.memRead;
    assign dmemReq.write = exMem.valid && exMem.memWrite;

    // ------------------------------------------------------------------------
    // Branch resolution
    // ------------------------------------------------------------------------
    assign isBranch = exMem.valid && exMem.branch;
    assign mispredict = isBranch && (exMem.actualTaken != exMem.predTaken);
    assign fallThrough = exMem.pc + wordT'(4);

    assign redirect.valid = mispredict;
    assign redirect.target = exMem.actualTaken ? exMem.target : fallThrough;

    // Every resolved branch trains the predictor
    assign bhtUpdate.valid = isBranch;
    assign bhtUpdate.pc = exMem.pc;
    assign bhtUpdate.taken = exMem.actualTaken;

    // MEM/WB register
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            writeBack <= '0;
        end else begin
            writeBack.regWrite <= exMem.valid && exMem.regWrite;
            writeBack.rd <= exMem.rd;
            writeBack.data <= exMem.memRead ? dataRead : exMem.aluResult;
        end
    end

endmodule

/* src/executeStage.sv */
`include "mips_defines.svh"

module executeStage (
    input  logic               CLK,
    input  logic               rstN,
    input  mipsPipePkg::idExT  idEx,
    input  logic               flush,
    output mipsPipePkg::exMemT exMem
);
    import mipsPipePkg::*;

    wordT aluB;
    wordT aluResult;
    wordT target;
    logic equal;
    logic taken;

    // Loads and stores add the offset here as well
    assign aluB = idEx.useImm ? idEx.imm : idEx.opB;

    always_comb begin
        case (idEx.aluOp)
            ALU_ADD: aluResult = idEx.opA + aluB;
            ALU_SUB: aluResult = idEx.opA - aluB;
            ALU_AND: aluResult = idEx.opA & aluB;
            ALU_OR:  aluResult = idEx.opA | aluB;
            ALU_SLT: aluResult = {{(`MIPS_XLEN-1){1'b0}}, $signed(idEx.opA) < $signed(aluB)};
            default: aluResult = '0;
        endcase
    end

    // Branch condition and target
    assign equal = (idEx.opA == idEx.opB);
    assign taken = idEx.branch && (idEx.branchEq ? equal : !equal);
    assign target = idEx.pc + wordT'(4) + {idEx.imm[`MIPS_XLEN-3:0], 2'b00};

    // EX/MEM register
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            exMem <= '0;
        end else begin
            exMem.valid <= idEx.valid && !flush;
            exMem.pc <= idEx.pc;
            exMem.aluResult <= aluResult;
            exMem.storeData <= idEx.opB;
            exMem.rd <= idEx.rd;
            exMem.regWrite <= idEx.regWrite;
            exMem.memRead <= idEx.memRead;
            exMem.memWrite <= idEx.memWrite;
            exMem.branch <= idEx.branch;
            exMem.actualTaken <= taken;
            exMem.target <= target;
            exMem.predTaken <= idEx.predTaken;
        end
    end

endmodule

/* src/decodeStage.sv */
`include "mips_defines.svh"

module decodeStage (
    input  logic               CLK,
    input  logic               rstN,
    input  mipsPipePkg::ifIdT  ifId,
    input  logic               flush,
    input  mipsPipePkg::memWbT writeBack,
    input  mipsPipePkg::exMemT exMem,
    output mipsPipePkg::idExT  idEx,
    output logic               stall
);
    import mipsIsaPkg::*;
    import mipsPipePkg::*;

    instrT       instr;
    logic [15:0] imm;
    wordT        dataA;
    wordT        dataB;
    idExT        decoded;
    logic        useRt;
    logic        busyEx;
    logic        busyMem;
    logic        hazardRs;
    logic        hazardRt;

    registerFile u_registerFile (
        .CLK      (CLK),
        .rstN     (rstN),
        .readA    (instr.rs),
        .readB    (instr.rt),
        .dataA    (dataA),
        .dataB    (dataB),
        .writeBack(writeBack)
    );

    assign instr = instrT'(ifId.instr);
    assign imm = immField(instr);

    // ------------------------------------------------------------------------
    // Control decode
    // ------------------------------------------------------------------------
    always_comb begin
        decoded = '0;
        decoded.pc = ifId.pc;
        decoded.opA = dataA;
        decoded.opB = dataB;
        decoded.imm = {{(`MIPS_XLEN-16){imm[15]}}, imm};
        decoded.aluOp = ALU_ADD;
        decoded.predTaken = ifId.predTaken;
        useRt = 1'b0;
        case (instr.opcode)
            OP_SPECIAL: begin
                useRt = 1'b1;
                decoded.rd = instr.rd;
                decoded.regWrite = 1'b1;
                case (instr.funct)
                    FN_ADDU: decoded.aluOp = ALU_ADD;
                    FN_SUBU: decoded.aluOp = ALU_SUB;
                    FN_AND:  decoded.aluOp = ALU_AND;
                    FN_OR:   decoded.aluOp = ALU_OR;
                    FN_SLT:  decoded.aluOp = ALU_SLT;
                    // Anything else retires as a nop
                    default: decoded.regWrite = 1'b0;
                endcase
            end
            OP_ADDIU, OP_LW: begin
                decoded.useImm = 1'b1;
                decoded.rd = instr.rt;
                decoded.regWrite = 1'b1;
                decoded.memRead = (instr.opcode == OP_LW);
            end
            OP_SW: begin
                useRt = 1'b1;
                decoded.useImm = 1'b1;
                decoded.memWrite = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                useRt = 1'b1;
                decoded.branch = 1'b1;
                decoded.branchEq = (instr.opcode == OP_BEQ);
            end
            default: ;
        endcase
    end

    // ------------------------------------------------------------------------
    // Interlock against results not yet in the register file
    // ------------------------------------------------------------------------
    assign busyEx = idEx.valid && idEx.regWrite;
    assign busyMem = exMem.valid && exMem.regWrite;
    assign hazardRs = (instr.rs != '0) &&
                      ((busyEx && idEx.rd == instr.rs) || (busyMem && exMem.rd == instr.rs));
    assign hazardRt = useRt && (instr.rt != '0) &&
                      ((busyEx && idEx.rd == instr.rt) || (busyMem && exMem.rd == instr.rt));
    assign stall = ifId.valid && (hazardRs || hazardRt);

    // ID/EX register, bubble on stall or flush
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            idEx <= '0;
        end else begin
            idEx <= decoded;
            idEx.valid <= ifId.valid && !stall && !flush;
        end
    end

endmodule

/* src/registerFile.sv */
`include "mips_defines.svh"

module registerFile (
    input  logic                CLK,
    input  logic                rstN,
    input  mipsPipePkg::regIdxT readA,
    input  mipsPipePkg::regIdxT readB,
    output mipsPipePkg::wordT   dataA,
    output mipsPipePkg::wordT   dataB,
    input  mipsPipePkg::memWbT  writeBack
);
    import mipsPipePkg::*;

    wordT regs [`MIPS_REGS];
    logic writing;

    // Register 0 is never written
    assign writing = writeBack.regWrite && (writeBack.rd != '0);

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `MIPS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writing) begin
            regs[writeBack.rd] <= writeBack.data;
        end
    end

    // Write-through so the MEM/WB result is visible in decode
    assign dataA = (readA == '0) ? '0 :
                   (writing && writeBack.rd == readA) ? writeBack.data : regs[readA];
    assign dataB = (readB == '0) ? '0 :
                   (writing && writeBack.rd == readB) ? writeBack.data : regs[readB];

endmodule

/* src/fetchStage.sv */
`include "mips_defines.svh"

module fetchStage (
    input  logic                   CLK,
    input  logic                   rstN,
    output mipsPipePkg::wordT      instrAddr,
    input  mipsPipePkg::wordT      instrRead,
    input  logic                   stall,
    input  logic                   flush,
    input  mipsPipePkg::redirectT  redirect,
    input  mipsPipePkg::bhtUpdateT bhtUpdate,
    output mipsPipePkg::ifIdT      ifId
);
    import mipsIsaPkg::*;
    import mipsPipePkg::*;

    wordT        pc;
    wordT        nextPc;
    wordT        branchTarget;
    instrT       fetched;
    logic [15:0] imm;
    logic        bhtTaken;
    logic        isBranch;
    logic        predTaken;

    branchHistoryTable u_branchHistoryTable (
        .CLK         (CLK),
        .rstN        (rstN),
        .lookupPc    (pc),
        .predictTaken(bhtTaken),
        .update      (bhtUpdate)
    );

    assign instrAddr = pc;
    assign fetched = instrT'(instrRead);
    assign imm = immField(fetched);

    // Only conditional branches consult the predictor
    assign isBranch = (fetched.opcode == OP_BEQ) || (fetched.opcode == OP_BNE);
    assign predTaken = isBranch && bhtTaken;
    assign branchTarget = pc + wordT'(4) + {{(`MIPS_XLEN-18){imm[15]}}, imm, 2'b00};

    always_comb begin
        if (redirect.valid) begin
            nextPc = redirect.target;
        end else if (stall) begin
            nextPc = pc;
        end else if (predTaken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pc + wordT'(4);
        end
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            pc <= `MIPS_RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

    // IF/ID register
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            ifId <= '0;
        end else if (flush) begin
            ifId.valid <= 1'b0;
        end else if (!stall) begin
            ifId.valid <= 1'b1;
            ifId.pc <= pc;
            ifId.instr <= instrRead;
            ifId.predTaken <= predTaken;
        end
    end

endmodule

/* src/branchHistoryTable.sv */
`include "mips_defines.svh"

module branchHistoryTable (
    input  logic                   CLK,
    input  logic                   rstN,
    input  mipsPipePkg::wordT      lookupPc,
    output logic                   predictTaken,
    input  mipsPipePkg::bhtUpdateT update
);
    localparam int IdxBits = $clog2(`BHT_ENTRIES);

    // Two-bit saturating counters
    logic [1:0] counters [`BHT_ENTRIES];

    logic [IdxBits-1:0] lookupIdx;
    logic [IdxBits-1:0] updateIdx;
    logic [1:0]         current;

    // Word address bits, byte offset dropped
    assign lookupIdx = lookupPc[IdxBits+1:2];
    assign updateIdx = update.pc[IdxBits+1:2];

    assign predictTaken = counters[lookupIdx][1];
    assign current = counters[updateIdx];

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            // Weakly not-taken
            for (int i = 0; i < `BHT_ENTRIES; i++) begin
                counters[i] <= 2'b01;
            end
        end else if (update.valid) begin
            if (update.taken && current != 2'b11) begin
                counters[updateIdx] <= current + 2'b01;
            end else if (!update.taken && current != 2'b00) begin
                counters[updateIdx] <= current - 2'b01;
            end
        end
    end

endmodule

/* src/mipsPipePkg.sv */
`include "mips_defines.svh"

package mipsPipePkg;

    typedef logic [`MIPS_XLEN-1:0] wordT;
    typedef logic [$clog2(`MIPS_REGS)-1:0] regIdxT;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } aluOpT;

    // ------------------------------------------------------------------------
    // Pipeline registers
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic valid;
        wordT pc;
        wordT instr;
        logic predTaken;
    } ifIdT;

    typedef struct packed {
        logic   valid;
        wordT   pc;
        wordT   opA;
        wordT   opB;
        wordT   imm;
        logic   useImm;
        aluOpT  aluOp;
        regIdxT rd;
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   branch;
        logic   branchEq;
        logic   predTaken;
    } idExT;

    typedef struct packed {
        logic   valid;
        wordT   pc;
        wordT   aluResult;
        wordT   storeData;
        regIdxT rd;
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   branch;
        logic   actualTaken;
        wordT   target;
        logic   predTaken;
    } exMemT;

    typedef struct packed {
        logic   regWrite;
        regIdxT rd;
        wordT   data;
    } memWbT;

    // ------------------------------------------------------------------------
    // Control links and the data memory port
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic valid;
        wordT target;
    } redirectT;

    typedef struct packed {
        logic valid;
        wordT pc;
        logic taken;
    } bhtUpdateT;

    typedef struct packed {
        wordT addr;
        wordT wdata;
        logic read;
        logic write;
    } dmemReqT;

endpackage

/* src/mipsIsaPkg.sv */
`include "mips_defines.svh"

package mipsIsaPkg;

    // ------------------------------------------------------------------------
    // Primary opcodes of the supported subset
    // ------------------------------------------------------------------------
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcodeT;

    // Function field of the special class
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } functT;

    // R-type layout; I-type immediate sits in rd, shamt and funct
    typedef struct packed {
        opcodeT     opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        functT      funct;
    } instrT;

    // Raw 16-bit immediate of an I-type word
    function automatic logic [15:0] immField(instrT instr);
        return {instr.rd, instr.shamt, instr.funct};
    endfunction

endpackage

/* src/mips_defines.svh */
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// ------------------------------------------------------------------------
// Core sizing
// ------------------------------------------------------------------------

// Data path and address width
`define MIPS_XLEN 32

// General purpose registers
`define MIPS_REGS 32

// First fetch address out of reset
`define MIPS_RESET_PC 32'h0000_0000

// Bimodal counters, indexed by PC word address
`define BHT_ENTRIES 64

`endif
